// ==== verilog/icache_pkg.sv ====
// Instruction cache package holding the address fields, vector types and line records
package icache_pkg;

	// ======================================================================
	// Address layout: tag | set | bank | byte offset
	// ======================================================================

	localparam int ADDR_W     = 32;
	localparam int LINE_BYTES = 16;
	localparam int OFFS_W     = $clog2(LINE_BYTES);
	// The lowest line-number bit picks the even or the odd bank
	localparam int BANK_BIT   = OFFS_W;
	localparam int SETS       = 16;
	localparam int SET_W      = $clog2(SETS);
	localparam int WAYS       = 4;
	localparam int WAY_W      = $clog2(WAYS);
	// Tag starts just above the set index
	localparam int TAG_LSB    = BANK_BIT + 1 + SET_W;
	localparam int TAG_W      = ADDR_W - TAG_LSB;
	localparam int LINE_W     = LINE_BYTES * 8;

	// ======================================================================
	// Vector types
	// ======================================================================

	typedef logic [ADDR_W-1:0]        addr_t;
	// Address with the byte offset dropped
	typedef logic [ADDR_W-OFFS_W-1:0] line_adr_t;
	typedef logic [SET_W-1:0]         set_idx_t;
	typedef logic [WAY_W-1:0]         way_t;
	typedef logic [TAG_W-1:0]         tag_t;
	typedef logic [LINE_W-1:0]        line_data_t;
	typedef logic [5:0]               cid_t;

	// Bus id of this core, snoops carrying it come from our own writes
	localparam cid_t ICACHE_CID = 6'd1;

	// ======================================================================
	// Line records
	// ======================================================================

	// Refill from the memory side
	typedef struct packed {
		line_adr_t  vadr;
		tag_t       ptag;
		line_data_t data;
	} fill_line_t;

	// Line handed to the fetch unit
	typedef struct packed {
		logic       v;
		line_adr_t  vadr;
		line_data_t data;
	} fetch_line_t;

	// Write seen on the shared bus
	typedef struct packed {
		addr_t adr;
		cid_t  cid;
	} snoop_t;

endpackage

// ==== verilog/icache_line_ram.sv ====
// Line data store of one bank with one write port and a registered read port
`timescale 1ns/1ps

module icache_line_ram import icache_pkg::*; (
	input  logic       clk,
	input  logic       wr_i,
	input  way_t       wr_way_i,
	input  set_idx_t   wr_set_i,
	input  line_data_t wr_data_i,
	input  way_t       rd_way_i,
	input  set_idx_t   rd_set_i,
	output line_data_t rd_data_o
);

	// One entry per way and set, indexed as {way, set}
	line_data_t mem [WAYS*SETS];

	// Refill write
	always_ff @(posedge clk) begin
		if (wr_i) begin
			mem[{wr_way_i, wr_set_i}] <= wr_data_i;
		end
	end

	// Read is registered so the data lines up with the registered hit
	// A read of the slot being written on the same edge returns the old line
	always_ff @(posedge clk) begin
		rd_data_o <= mem[{rd_way_i, rd_set_i}];
	end

endmodule

// ==== verilog/icache_tag_ram.sv ====
// Virtual and physical tag store of one bank with a fetch port and a snoop port
`timescale 1ns/1ps

module icache_tag_ram import icache_pkg::*; (
	input  logic                 clk,
	input  logic                 wr_i,
	input  way_t                 wr_way_i,
	input  set_idx_t             wr_set_i,
	input  tag_t                 wr_vtag_i,
	input  tag_t                 wr_ptag_i,
	input  set_idx_t             rd_set_i,
	output tag_t [WAYS-1:0]      vtags_o,
	input  set_idx_t             snoop_set_i,
	output tag_t [WAYS-1:0]      ptags_o
);

	// Virtual tags are matched against the fetch address
	tag_t vtag_q [WAYS][SETS];
	// Physical tags are matched against snooped bus writes
	tag_t ptag_q [WAYS][SETS];

	// ======================================================================
	// Refill writes both tags of the chosen way
	// ======================================================================

	always_ff @(posedge clk) begin
		if (wr_i) begin
			vtag_q[wr_way_i][wr_set_i] <= wr_vtag_i;
			ptag_q[wr_way_i][wr_set_i] <= wr_ptag_i;
		end
	end

	// ======================================================================
	// Combinational reads of all ways at once
	// ======================================================================

	// Fetch port feeds the way compare in the same cycle
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			vtags_o[w] = vtag_q[w][rd_set_i];
		end
	end

	// Snoop port feeds the valid clear logic
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			ptags_o[w] = ptag_q[w][snoop_set_i];
		end
	end

endmodule

// ==== verilog/icache_valid_ctrl.sv ====
// Valid bits of one bank, set on refill and cleared on invalidate or snoop
`timescale 1ns/1ps

module icache_valid_ctrl import icache_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            fill_i,
	input  way_t            fill_way_i,
	input  set_idx_t        fill_set_i,
	input  logic            inv_i,
	input  logic            inv_all_i,
	input  logic            inv_line_i,
	input  set_idx_t        inv_set_i,
	input  logic            snoop_inv_i,
	input  tag_t            snoop_tag_i,
	input  set_idx_t        snoop_set_i,
	input  tag_t [WAYS-1:0] ptags_i,
	input  set_idx_t        rd_set_i,
	output logic [WAYS-1:0] valid_o
);

	// One bit per way for every set
	logic [WAYS-1:0] valid_q [SETS];
	// Ways in the snooped set whose physical tag equals the snoop tag
	logic [WAYS-1:0] snoop_match;

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			snoop_match[w] = (ptags_i[w] == snoop_tag_i);
		end
	end

	// ======================================================================
	// Valid array update
	// ======================================================================

	// Later assignments in this block take priority over earlier ones
	// so a refill wins over an invalidate or a snoop of the same slot
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else begin
			// Snoop of a foreign write drops every matching way
			if (snoop_inv_i) begin
				valid_q[snoop_set_i] <= valid_q[snoop_set_i] & ~snoop_match;
			end
			// Single line invalidate takes precedence over the full one
			if (inv_i) begin
				if (inv_line_i) begin
					valid_q[inv_set_i] <= '0;
				end else if (inv_all_i) begin
					for (int s = 0; s < SETS; s++) begin
						valid_q[s] <= '0;
					end
				end
			end
			if (fill_i) begin
				valid_q[fill_set_i][fill_way_i] <= 1'b1;
			end
		end
	end

	// Fetch side read is combinational, it feeds the way compare
	assign valid_o = valid_q[rd_set_i];

endmodule

// ==== verilog/icache_way_match.sv ====
// Way compare of one bank, registering the hit and steering the data read
`timescale 1ns/1ps

module icache_way_match import icache_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  tag_t            tag_i,
	input  tag_t [WAYS-1:0] vtags_i,
	input  logic [WAYS-1:0] valid_i,
	output logic            hit_o,
	output way_t            way_o
);

	// Per-way match, only valid entries count
	logic [WAYS-1:0] match;
	// Hit held for the cycle in which the line data comes out
	logic            hit_q;

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			match[w] = valid_i[w] && (vtags_i[w] == tag_i);
		end
	end

	// ======================================================================
	// Way select
	// ======================================================================

	// Refill never loads the same line twice, so at most one way matches
	// The lowest matching way is taken anyway
	always_comb begin
		way_o = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (match[w]) begin
				way_o = way_t'(w);
			end
		end
	end

	// Registered on the same edge that reads the line store
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= |match;
		end
	end

	assign hit_o = hit_q;

endmodule

// ==== verilog/icache_bank.sv ====
// One parity bank of the fetch cache: tags, valid bits, way compare and line data
`timescale 1ns/1ps

module icache_bank import icache_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  set_idx_t   rd_set_i,
	input  tag_t       rd_tag_i,
	input  logic       fill_wr_i,
	input  fill_line_t fill_i,
	input  way_t       fill_way_i,
	input  logic       inv_i,
	input  logic       inv_all_i,
	input  logic       inv_line_i,
	input  logic       snoop_inv_i,
	input  addr_t      snoop_adr_i,
	output logic       hit_o,
	output line_data_t data_o
);

	// Refill line as a byte address, so the usual fields can be sliced
	addr_t           fill_adr;
	set_idx_t        fill_set;
	tag_t            fill_vtag;
	set_idx_t        snoop_set;
	tag_t            snoop_tag;
	tag_t [WAYS-1:0] vtags;
	tag_t [WAYS-1:0] ptags;
	logic [WAYS-1:0] valid;
	way_t            rd_way;

	assign fill_adr  = {fill_i.vadr, {OFFS_W{1'b0}}};
	assign fill_set  = fill_adr[TAG_LSB-1:BANK_BIT+1];
	assign fill_vtag = fill_adr[ADDR_W-1:TAG_LSB];

	// The set bits lie below the page offset, so physical and virtual
	// indexes agree and only one set has to be searched
	assign snoop_set = snoop_adr_i[TAG_LSB-1:BANK_BIT+1];
	assign snoop_tag = snoop_adr_i[ADDR_W-1:TAG_LSB];

	// ======================================================================
	// Tag and valid state
	// ======================================================================

	icache_tag_ram u_tags (
		.clk        (clk),
		.wr_i       (fill_wr_i),
		.wr_way_i   (fill_way_i),
		.wr_set_i   (fill_set),
		.wr_vtag_i  (fill_vtag),
		.wr_ptag_i  (fill_i.ptag),
		.rd_set_i   (rd_set_i),
		.vtags_o    (vtags),
		.snoop_set_i(snoop_set),
		.ptags_o    (ptags)
	);

	// A single line invalidate names its line through the refill address
	icache_valid_ctrl u_valid (
		.clk        (clk),
		.rst        (rst),
		.fill_i     (fill_wr_i),
		.fill_way_i (fill_way_i),
		.fill_set_i (fill_set),
		.inv_i      (inv_i),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_line_i),
		.inv_set_i  (fill_set),
		.snoop_inv_i(snoop_inv_i),
		.snoop_tag_i(snoop_tag),
		.snoop_set_i(snoop_set),
		.ptags_i    (ptags),
		.rd_set_i   (rd_set_i),
		.valid_o    (valid)
	);

	// ======================================================================
	// Lookup and data
	// ======================================================================

	icache_way_match u_match (
		.clk    (clk),
		.rst    (rst),
		.tag_i  (rd_tag_i),
		.vtags_i(vtags),
		.valid_i(valid),
		.hit_o  (hit_o),
		.way_o  (rd_way)
	);

	icache_line_ram u_lines (
		.clk      (clk),
		.wr_i     (fill_wr_i),
		.wr_way_i (fill_way_i),
		.wr_set_i (fill_set),
		.wr_data_i(fill_i.data),
		.rd_way_i (rd_way),
		.rd_set_i (rd_set_i),
		.rd_data_o(data_o)
	);

endmodule

// ==== verilog/icache_top.sv ====
// Dual-line instruction fetch cache returning the fetch line and the one after it
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  addr_t       fetch_adr_i,
	input  logic        fill_wr_i,
	input  fill_line_t  fill_i,
	input  way_t        fill_way_i,
	input  logic        inv_i,
	input  logic        inv_all_i,
	input  logic        inv_line_i,
	input  logic        snoop_v_i,
	input  snoop_t      snoop_i,
	output addr_t       fetch_adr_o,
	output logic        ihit_o,
	output fetch_line_t line_lo_o,
	output fetch_line_t line_hi_o,
	output addr_t       miss_adr_o
);

	line_adr_t  fetch_line;
	line_adr_t  even_line;
	addr_t      even_adr;
	addr_t      fill_adr;
	logic       fill_odd;
	logic       snoop_ok;
	addr_t      fetch_adr_q;
	line_adr_t  lo_line;
	line_adr_t  hi_line;
	logic       odd_q;
	logic       hit_even;
	logic       hit_odd;
	line_data_t data_even;
	line_data_t data_odd;
	logic       lo_hit;
	logic       hi_hit;

	// ======================================================================
	// Fetch index per bank
	// ======================================================================

	// The odd bank always holds one of the two lines at the fetch index
	// The even bank looks one line ahead when the fetch line is odd
	// Adding on the whole line number carries into the tag at the last set
	assign fetch_line = fetch_adr_i[ADDR_W-1:OFFS_W];
	assign even_line  = fetch_line + line_adr_t'(fetch_adr_i[BANK_BIT]);
	assign even_adr   = {even_line, {OFFS_W{1'b0}}};

	// ======================================================================
	// Refill, invalidate and snoop steering
	// ======================================================================

	assign fill_adr = {fill_i.vadr, {OFFS_W{1'b0}}};
	assign fill_odd = fill_adr[BANK_BIT];

	// Foreign writes only, our own stores are already reflected in the line
	assign snoop_ok = snoop_v_i && (snoop_i.cid != ICACHE_CID);

	icache_bank bank_even (
		.clk        (clk),
		.rst        (rst),
		.rd_set_i   (even_adr[TAG_LSB-1:BANK_BIT+1]),
		.rd_tag_i   (even_adr[ADDR_W-1:TAG_LSB]),
		.fill_wr_i  (fill_wr_i && !fill_odd),
		.fill_i     (fill_i),
		.fill_way_i (fill_way_i),
		// A line invalidate goes to the bank that owns the line, a full one to both
		.inv_i      (inv_i && (!inv_line_i || !fill_odd)),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_line_i),
		.snoop_inv_i(snoop_ok && !snoop_i.adr[BANK_BIT]),
		.snoop_adr_i(snoop_i.adr),
		.hit_o      (hit_even),
		.data_o     (data_even)
	);

	icache_bank bank_odd (
		.clk        (clk),
		.rst        (rst),
		.rd_set_i   (fetch_adr_i[TAG_LSB-1:BANK_BIT+1]),
		.rd_tag_i   (fetch_adr_i[ADDR_W-1:TAG_LSB]),
		.fill_wr_i  (fill_wr_i && fill_odd),
		.fill_i     (fill_i),
		.fill_way_i (fill_way_i),
		.inv_i      (inv_i && (!inv_line_i || fill_odd)),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_line_i),
		.snoop_inv_i(snoop_ok && snoop_i.adr[BANK_BIT]),
		.snoop_adr_i(snoop_i.adr),
		.hit_o      (hit_odd),
		.data_o     (data_odd)
	);

	// ======================================================================
	// Registered fetch address and line ordering
	// ======================================================================

	// Captured on the lookup edge, so it pairs with the bank outputs
	always_ff @(posedge clk) begin
		fetch_adr_q <= fetch_adr_i;
	end

	assign fetch_adr_o = fetch_adr_q;
	assign lo_line     = fetch_adr_q[ADDR_W-1:OFFS_W];
	assign hi_line     = lo_line + line_adr_t'(1);
	assign odd_q       = fetch_adr_q[BANK_BIT];

	// Odd fetch line: the odd bank gives the low line and the even bank the next
	assign lo_hit = odd_q ? hit_odd : hit_even;
	assign hi_hit = odd_q ? hit_even : hit_odd;

	always_comb begin
		line_lo_o.v    = lo_hit;
		line_lo_o.vadr = lo_line;
		line_lo_o.data = odd_q ? data_odd : data_even;
		line_hi_o.v    = hi_hit;
		line_hi_o.vadr = hi_line;
		line_hi_o.data = odd_q ? data_even : data_odd;
	end

	// A fetch may straddle both lines, so both must be present
	assign ihit_o = hit_even && hit_odd;

	// Low line is requested first, zero once both lines are in
	always_comb begin
		if (!lo_hit) begin
			miss_adr_o = {lo_line, {OFFS_W{1'b0}}};
		end else if (!hi_hit) begin
			miss_adr_o = {hi_line, {OFFS_W{1'b0}}};
		end else begin
			miss_adr_o = '0;
		end
	end

endmodule

// ==== tb/icache_tb_sva.sv ====
// Port-level assertions of the dual-line fetch cache, bound into the top level
`timescale 1ns/1ps

module icache_tb_sva import icache_pkg::*; (
	input logic        clk,
	input logic        rst,
	input addr_t       fetch_adr_o,
	input logic        ihit_o,
	input fetch_line_t line_lo_o,
	input addr_t       miss_adr_o
);

	// Number of assertion failures seen so far
	int unsigned fail_cnt = 0;

	// All valid bits are clear during reset, so nothing can hit right after it
	a_no_hit_after_reset: assert property (@(posedge clk) rst |=> !ihit_o)
		else begin
			$error("ihit_o is high on the cycle after reset");
			fail_cnt++;
		end

	// A refill request always names a whole line
	a_miss_aligned: assert property (@(posedge clk) disable iff (rst)
		!ihit_o |-> (miss_adr_o[OFFS_W-1:0] == '0))
		else begin
			$error("miss_adr_o has a nonzero byte offset");
			fail_cnt++;
		end

	// The low line is the line of the registered fetch address
	a_low_line: assert property (@(posedge clk) disable iff (rst)
		line_lo_o.vadr == fetch_adr_o[ADDR_W-1:OFFS_W])
		else begin
			$error("line_lo_o.vadr is not the line of fetch_adr_o");
			fail_cnt++;
		end

endmodule

// ==== tb/icache_tb.sv ====
// Testbench for the dual-line fetch cache, with a reference model and a comparison process
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

	bind icache_top icache_tb_sva sva0 (
		.clk(clk), .rst(rst), .fetch_adr_o(fetch_adr_o), .ihit_o(ihit_o),
		.line_lo_o(line_lo_o), .miss_adr_o(miss_adr_o)
	);

	// Cycle budgets of the six tests, then room for reset and draining
	localparam int BUDGET = 30 + 30 + 30 + 50 + 40 + 40;
	localparam int MARGIN = 50;
	localparam line_adr_t NEXT = 1;

	typedef logic [159:0] cmp_t;

	// Everything the DUT should show one cycle after a fetch
	typedef struct packed {
		addr_t       fadr;
		logic        hit;
		fetch_line_t lo;
		fetch_line_t hi;
		addr_t       miss;
	} exp_t;

	logic        clk;
	logic        rst;
	addr_t       fetch_adr_i;
	logic        fill_wr_i;
	fill_line_t  fill_i;
	way_t        fill_way_i;
	logic        inv_i;
	logic        inv_all_i;
	logic        inv_line_i;
	logic        snoop_v_i;
	snoop_t      snoop_i;
	addr_t       fetch_adr_o;
	logic        ihit_o;
	fetch_line_t line_lo_o;
	fetch_line_t line_hi_o;
	addr_t       miss_adr_o;

	logic [31:0] rng;
	int          checks;
	int          errors;
	int          test_err;
	exp_t        exp_q [$];
	exp_t        cur;
	logic        chk_v;
	logic        chk_q;
	logic [31:0] r;
	line_adr_t   b;
	line_adr_t   m;
	line_adr_t   l;
	tag_t        t;
	tag_t        pt;
	set_idx_t    s;

	// Reference state, indexed by bank, way and set
	logic       m_valid [2][WAYS][SETS];
	tag_t       m_vtag  [2][WAYS][SETS];
	tag_t       m_ptag  [2][WAYS][SETS];
	line_data_t m_data  [2][WAYS][SETS];

	icache_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ======================================================================
	// Random numbers and the reference model
	// ======================================================================

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Looks a line up in the model; bank from the lowest line bit, set above it
	function automatic logic ref_lookup(input line_adr_t ln, output line_data_t d);
		addr_t    la;
		set_idx_t st;
		tag_t     tg;
		logic     hit;
		la  = {ln, {OFFS_W{1'b0}}};
		st  = la[TAG_LSB-1:BANK_BIT+1];
		tg  = la[ADDR_W-1:TAG_LSB];
		hit = 1'b0;
		d   = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[la[BANK_BIT]][w][st] && (m_vtag[la[BANK_BIT]][w][st] == tg)) begin
				hit = 1'b1;
				d   = m_data[la[BANK_BIT]][w][st];
			end
		end
		return hit;
	endfunction

	// Low line holds the fetch address, high line is the one after it
	function automatic exp_t predict(input addr_t fa);
		exp_t       e;
		line_adr_t  lo;
		line_data_t dl;
		line_data_t dh;
		logic       hl;
		logic       hh;
		lo     = fa[ADDR_W-1:OFFS_W];
		hl     = ref_lookup(lo, dl);
		hh     = ref_lookup(lo + NEXT, dh);
		e.fadr = fa;
		e.hit  = hl && hh;
		e.lo   = {hl, lo, dl};
		e.hi   = {hh, lo + NEXT, dh};
		// The low line is requested first
		if (!hl) begin
			e.miss = {lo, {OFFS_W{1'b0}}};
		end else if (!hh) begin
			e.miss = {lo + NEXT, {OFFS_W{1'b0}}};
		end else begin
			e.miss = '0;
		end
		return e;
	endfunction

	// ======================================================================
	// Stimulus tasks, each one strobe cycle plus one idle cycle
	// ======================================================================

	task automatic fill_line(input line_adr_t ln, input way_t w, input tag_t p);
		addr_t      la;
		set_idx_t   st;
		line_data_t d;
		la = {ln, {OFFS_W{1'b0}}};
		st = la[TAG_LSB-1:BANK_BIT+1];
		d  = {next_rand(), next_rand(), next_rand(), next_rand()};
		@(posedge clk);
		fill_wr_i  <= 1'b1;
		fill_i     <= {ln, p, d};
		fill_way_i <= w;
		m_valid[la[BANK_BIT]][w][st] = 1'b1;
		m_vtag[la[BANK_BIT]][w][st]  = la[ADDR_W-1:TAG_LSB];
		m_ptag[la[BANK_BIT]][w][st]  = p;
		m_data[la[BANK_BIT]][w][st]  = d;
		@(posedge clk);
		fill_wr_i <= 1'b0;
	endtask

	task automatic fetch(input addr_t fa);
		@(posedge clk);
		fetch_adr_i <= fa;
		chk_v       <= 1'b1;
		exp_q.push_back(predict(fa));
		@(posedge clk);
		chk_v <= 1'b0;
	endtask

	// A single-line invalidate clears the whole set of the owning bank
	task automatic invalidate(input logic all, input line_adr_t ln);
		addr_t la;
		la = {ln, {OFFS_W{1'b0}}};
		@(posedge clk);
		inv_i       <= 1'b1;
		inv_all_i   <= all;
		inv_line_i  <= !all;
		fill_i.vadr <= ln;
		for (int w = 0; w < WAYS; w++) begin
			for (int st = 0; st < SETS; st++) begin
				if (all || (la[BANK_BIT] == 1'b0 && st == la[TAG_LSB-1:BANK_BIT+1])) begin
					m_valid[0][w][st] = 1'b0;
				end
				if (all || (la[BANK_BIT] == 1'b1 && st == la[TAG_LSB-1:BANK_BIT+1])) begin
					m_valid[1][w][st] = 1'b0;
				end
			end
		end
		@(posedge clk);
		inv_i <= 1'b0;
	endtask

	task automatic snoop(input addr_t sa, input cid_t c);
		set_idx_t st;
		st = sa[TAG_LSB-1:BANK_BIT+1];
		@(posedge clk);
		snoop_v_i <= 1'b1;
		snoop_i   <= {sa, c};
		// Only writes of other cores drop ways with the same physical tag
		if (c != ICACHE_CID) begin
			for (int w = 0; w < WAYS; w++) begin
				if (m_ptag[sa[BANK_BIT]][w][st] == sa[ADDR_W-1:TAG_LSB]) begin
					m_valid[sa[BANK_BIT]][w][st] = 1'b0;
				end
			end
		end
		@(posedge clk);
		snoop_v_i <= 1'b0;
	endtask

	// ======================================================================
	// Comparison and reporting
	// ======================================================================

	task automatic check(input string what, input cmp_t got, input cmp_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// The lookup result appears one edge after the fetch address is sampled
	always @(posedge clk) begin
		chk_q <= chk_v;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (chk_q && exp_q.size() != 0) begin
			cur = exp_q.pop_front();
			check("fetch_adr_o", cmp_t'(fetch_adr_o), cmp_t'(cur.fadr));
			check("ihit_o", cmp_t'(ihit_o), cmp_t'(cur.hit));
			check("miss_adr_o", cmp_t'(miss_adr_o), cmp_t'(cur.miss));
			check("line_lo_o.v", cmp_t'(line_lo_o.v), cmp_t'(cur.lo.v));
			check("line_lo_o.vadr", cmp_t'(line_lo_o.vadr), cmp_t'(cur.lo.vadr));
			check("line_hi_o.v", cmp_t'(line_hi_o.v), cmp_t'(cur.hi.v));
			check("line_hi_o.vadr", cmp_t'(line_hi_o.vadr), cmp_t'(cur.hi.vadr));
			// Data of a missing line is undefined
			if (cur.lo.v) begin
				check("line_lo_o.data", cmp_t'(line_lo_o.data), cmp_t'(cur.lo.data));
			end
			if (cur.hi.v) begin
				check("line_hi_o.data", cmp_t'(line_hi_o.data), cmp_t'(cur.hi.data));
			end
		end
	end

	task automatic end_test(input int num, input string name);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		$display("test %0d, %s: %0d errors", num, name, errors - test_err);
		test_err = errors;
	endtask

	initial begin
		#((BUDGET + MARGIN) * 4);
		$display("Timeout: the tests did not finish within %0d cycles", BUDGET + MARGIN);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		rst         <= 1'b1;
		fetch_adr_i <= '0;
		fill_wr_i   <= 1'b0;
		fill_i      <= '0;
		fill_way_i  <= '0;
		inv_i       <= 1'b0;
		inv_all_i   <= 1'b0;
		inv_line_i  <= 1'b0;
		snoop_v_i   <= 1'b0;
		snoop_i     <= '0;
		chk_v       <= 1'b0;
		rng      = 32'h2fd6_1a2f;
		checks   = 0;
		errors   = 0;
		test_err = 0;
		for (int w = 0; w < WAYS; w++) begin
			for (int st = 0; st < SETS; st++) begin
				m_valid[0][w][st] = 1'b0;
				m_valid[1][w][st] = 1'b0;
			end
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// An empty cache misses on every fetch
		for (int i = 0; i < 8; i++) begin
			fetch(next_rand());
		end
		end_test(1, "random fetches after reset");

		// Even line in set 15, so the odd fetch reaches set 0 of the next tag
		r = next_rand();
		b = {r[22:0], 5'b11110};
		fill_line(b, r[25:24], tag_t'(next_rand()));
		fill_line(b + NEXT, r[27:26], tag_t'(next_rand()));
		fill_line(b + NEXT + NEXT, r[29:28], tag_t'(next_rand()));
		fetch({b, 4'h8});
		fetch({b + NEXT, 4'h2});
		fetch({b + NEXT, 4'hc});
		end_test(2, "hits with line ordering");

		// Set kept below 8 so the set 15 lines above survive until the invalidate test
		r = next_rand();
		m = {r[31:9], 1'b0, r[7:5], 1'b0};
		fill_line(m, 2'd1, tag_t'(next_rand()));
		fetch({m, 4'h0});
		fetch({m - NEXT, 4'h4});
		fetch({m + NEXT, 4'hc});
		end_test(3, "one line present");

		// Four line pairs with different tags share one set in both banks
		// The set stays below 8, away from the set 15 lines filled earlier
		r = next_rand();
		s = {1'b0, r[2:0]};
		t = r[31:9];
		for (int i = 0; i < WAYS; i++) begin
			l = {t + tag_t'(i), s, 1'b0};
			fill_line(l, way_t'(i), tag_t'(next_rand()));
			fill_line(l + NEXT, way_t'(i), tag_t'(next_rand()));
		end
		for (int i = 0; i < WAYS; i++) begin
			fetch({t + tag_t'(i), s, 1'b0, 4'h0});
		end
		l = {t + tag_t'(7), s, 1'b0};
		fill_line(l, 2'd2, tag_t'(next_rand()));
		fill_line(l + NEXT, 2'd2, tag_t'(next_rand()));
		fetch({l, 4'h0});
		fetch({t + tag_t'(2), s, 1'b0, 4'h6});
		end_test(4, "four ways and way replacement");

		invalidate(1'b0, {t, s, 1'b0});
		fetch({t, s, 1'b0, 4'h0});
		fetch({t + tag_t'(1), s, 1'b0, 4'h0});
		fetch({t + tag_t'(7), s, 1'b0, 4'h0});
		fetch({b, 4'h0});
		invalidate(1'b1, '0);
		fetch({b, 4'h0});
		fetch({b + NEXT, 4'h0});
		end_test(5, "line and full invalidate");

		// The physical address shares set and bank bits with the line
		r  = next_rand();
		m  = {r[31:5], 1'b0};
		pt = tag_t'(next_rand());
		fill_line(m, 2'd3, pt);
		fill_line(m + NEXT, 2'd0, tag_t'(next_rand()));
		fetch({m, 4'h0});
		snoop({pt, m[SET_W:0], 4'h0}, ICACHE_CID);
		fetch({m, 4'h0});
		snoop({~pt, m[SET_W:0], 4'h0}, cid_t'(9));
		fetch({m, 4'h0});
		snoop({pt, m[SET_W:0], 4'h0}, cid_t'(9));
		fetch({m, 4'h0});
		end_test(6, "snoop invalidate");

		$display("%0d checks, %0d errors, %0d assertion failures",
			checks, errors, dut0.sva0.fail_cnt);
		if (errors == 0 && dut0.sva0.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
verilog/icache_pkg.sv
verilog/icache_line_ram.sv
verilog/icache_tag_ram.sv
verilog/icache_valid_ctrl.sv
verilog/icache_way_match.sv
verilog/icache_bank.sv
verilog/icache_top.sv
tb/icache_tb_sva.sv
tb/icache_tb.sv

// ==== Makefile ====
TOP := icache_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build the testbench with Verilator, run it and look for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir build
	./build/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf build
